// ==== Bender.yml ====
package:
  name: kugelblitz_regfile

sources:
  # Shared package and interface first
  - files:
      - common/kg_regfile_pkg.sv
      - common/regfile_if.sv
      - logic/axil_ctrl.sv
      - logic/addr_capture.sv
      - reg_bank/reg_bank.sv
      - logic/kugelblitz_regfile.sv

  # Testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_kugelblitz_regfile.sv

// ==== bench/tb_axil_tasks.svh ====
// AXI4-Lite master tasks for the register file testbench
// Single-beat write and read, each with optional B or R back-pressure

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Called on a falling edge, returns on a falling edge
task automatic write_access(input addr_t addr, input data_t data, input strb_t strb,
                            input int stall);
    int waited;
    s_axil_awaddr = addr;
    s_axil_wdata = data;
    s_axil_wstrb = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid = 1'b1;
    waited = 0;
    while (!(s_axil_awready && s_axil_wready) && waited < WAIT_LIMIT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!(s_axil_awready && s_axil_wready))
    begin
        $display("%0t: awready and wready never rose for write to 0x%h", $time, addr);
        protocol_errors++;
    end
    // Handshake completes on the rising edge before this one
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    waited = 0;
    while (!s_axil_bvalid && waited < WAIT_LIMIT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!s_axil_bvalid)
    begin
        $display("%0t: no write response for address 0x%h", $time, addr);
        protocol_errors++;
    end
    else
    begin
        for (int i = 0; i < stall; i++)
        begin
            @(negedge clk);
            if (!s_axil_bvalid)
            begin
                $display("%0t: bvalid dropped while bready was low", $time);
                protocol_errors++;
            end
        end
        if (s_axil_bresp != RESP_OKAY)
        begin
            $display("MISMATCH at %0t: bresp 0x%0h for write to 0x%h", $time,
                     s_axil_bresp, addr);
            mismatch_count++;
        end
        s_axil_bready = 1'b1;
        @(negedge clk);
        s_axil_bready = 1'b0;
    end
endtask

task automatic read_access(input addr_t addr, input int stall, output data_t data);
    int waited;
    data_t first;
    s_axil_araddr = addr;
    s_axil_arvalid = 1'b1;
    waited = 0;
    while (!s_axil_arready && waited < WAIT_LIMIT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!s_axil_arready)
    begin
        $display("%0t: arready never rose for read of 0x%h", $time, addr);
        protocol_errors++;
    end
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    waited = 0;
    while (!s_axil_rvalid && waited < WAIT_LIMIT)
    begin
        @(negedge clk);
        waited++;
    end
    first = s_axil_rdata;
    data = first;
    if (!s_axil_rvalid)
    begin
        $display("%0t: no read data for address 0x%h", $time, addr);
        protocol_errors++;
    end
    else
    begin
        // Data must not move while the master holds rready low
        for (int i = 0; i < stall; i++)
        begin
            @(negedge clk);
            if (!s_axil_rvalid)
            begin
                $display("%0t: rvalid dropped while rready was low", $time);
                protocol_errors++;
            end
            if (s_axil_rdata !== first)
            begin
                $display("MISMATCH at %0t: rdata moved from 0x%h to 0x%h during stall",
                         $time, first, s_axil_rdata);
                mismatch_count++;
            end
        end
        if (s_axil_rresp != RESP_OKAY)
        begin
            $display("MISMATCH at %0t: rresp 0x%0h for read of 0x%h", $time,
                     s_axil_rresp, addr);
            mismatch_count++;
        end
        s_axil_rready = 1'b1;
        @(negedge clk);
        s_axil_rready = 1'b0;
    end
endtask

`endif

// ==== bench/tb_kugelblitz_regfile.sv ====
// Testbench for the AXI4-Lite register file
// Clock, reset, reference model, read compare process and test sequence

`timescale 1ns/1ps

module tb_kugelblitz_regfile;
    import kg_regfile_pkg::*;

    localparam int SEED = 92635;
    // About 2000 cycles of traffic in the sequence below, doubled for margin
    localparam int MAX_CYCLES = 4000;
    // Longest wait for one ready or valid
    localparam int WAIT_LIMIT = 20;

    logic clk;
    logic rst;
    addr_t s_axil_awaddr;
    logic s_axil_awvalid;
    logic s_axil_awready;
    data_t s_axil_wdata;
    strb_t s_axil_wstrb;
    logic s_axil_wvalid;
    logic s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic s_axil_bvalid;
    logic s_axil_bready;
    addr_t s_axil_araddr;
    logic s_axil_arvalid;
    logic s_axil_arready;
    data_t s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic s_axil_rvalid;
    logic s_axil_rready;
    data_t kg_address_valid;
    data_t kg_address;
    data_t kg_data_valid;
    data_t kg_data;

    data_t model [REG_COUNT];
    data_t exp_q [$];
    data_t got_q [$];
    int idx_q [$];
    data_t cmp_exp;
    data_t cmp_got;
    int cmp_idx;
    int mismatch_count = 0;
    int protocol_errors = 0;
    int read_count = 0;
    int cycle_count = 0;
    int unsigned seed_value;

    kugelblitz_regfile kugelblitz_regfile_i (
        .clk              (clk),
        .rst              (rst),
        .s_axil_awaddr    (s_axil_awaddr),
        .s_axil_awvalid   (s_axil_awvalid),
        .s_axil_awready   (s_axil_awready),
        .s_axil_wdata     (s_axil_wdata),
        .s_axil_wstrb     (s_axil_wstrb),
        .s_axil_wvalid    (s_axil_wvalid),
        .s_axil_wready    (s_axil_wready),
        .s_axil_bresp     (s_axil_bresp),
        .s_axil_bvalid    (s_axil_bvalid),
        .s_axil_bready    (s_axil_bready),
        .s_axil_araddr    (s_axil_araddr),
        .s_axil_arvalid   (s_axil_arvalid),
        .s_axil_arready   (s_axil_arready),
        .s_axil_rdata     (s_axil_rdata),
        .s_axil_rresp     (s_axil_rresp),
        .s_axil_rvalid    (s_axil_rvalid),
        .s_axil_rready    (s_axil_rready),
        .kg_address_valid (kg_address_valid),
        .kg_address       (kg_address),
        .kg_data_valid    (kg_data_valid),
        .kg_data          (kg_data)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // New bytes replace old ones only where the strobe is set
    function automatic data_t merge_strobes(input data_t old_word, input data_t new_word,
                                            input strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < STRB_WIDTH; b++)
        begin
            if (strb[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Byte address to word index, upper bits alias
    function automatic int word_index(input addr_t addr);
        return int'(addr[6:2]);
    endfunction

    `include "tb_axil_tasks.svh"

    task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb,
                             input int stall);
        int idx;
        idx = word_index(addr);
        write_access(addr, data, strb, stall);
        model[idx] = merge_strobes(model[idx], data, strb);
    endtask

    task automatic check_read(input addr_t addr, input int stall);
        data_t got;
        int idx;
        idx = word_index(addr);
        read_access(addr, stall, got);
        exp_q.push_back(model[idx]);
        idx_q.push_back(idx);
        got_q.push_back(got);
    endtask

    task automatic compare_export(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_exports();
        compare_export("kg_address_valid", kg_address_valid, model[0]);
        compare_export("kg_address", kg_address, model[1]);
        compare_export("kg_data_valid", kg_data_valid, model[2]);
        compare_export("kg_data", kg_data, model[3]);
    endtask

    // ------------------------------------------------------------
    // Read compare and run limit
    // ------------------------------------------------------------

    always @(negedge clk)
    begin
        while (got_q.size() > 0)
        begin
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            cmp_idx = idx_q.pop_front();
            read_count++;
            if (cmp_got !== cmp_exp)
            begin
                $display("MISMATCH at %0t: register %0d read 0x%h, expected 0x%h",
                         $time, cmp_idx, cmp_got, cmp_exp);
                mismatch_count++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Run stopped after %0d cycles before the sequence finished", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial
    begin
        addr_t addr;
        data_t data;
        strb_t strb;
        int idx;
        seed_value = $urandom(SEED);
        clk = 1'b0;
        rst = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        for (int i = 0; i < REG_COUNT; i++)
        begin
            model[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Reset values
        check_exports();
        for (int i = 0; i < REG_COUNT; i++)
        begin
            check_read(addr_t'(i << ADDR_LSB), 0);
        end

        // Full-word writes
        for (int i = 0; i < REG_COUNT; i++)
        begin
            data = $urandom;
            write_reg(addr_t'(i << ADDR_LSB), data, 4'hf, 0);
            check_read(addr_t'(i << ADDR_LSB), 0);
        end

        // Partial strobes
        repeat (64)
        begin
            idx = $urandom_range(REG_COUNT - 1, 0);
            data = $urandom;
            strb = strb_t'($urandom_range(15, 1));
            write_reg(addr_t'(idx << ADDR_LSB), data, strb, 0);
            check_read(addr_t'(idx << ADDR_LSB), 0);
        end

        // Aliased addresses: junk above bit 6 and in the byte offset
        for (int i = 0; i < REG_COUNT; i++)
        begin
            addr = addr_t'($urandom);
            addr[6:2] = i[4:0];
            data = $urandom;
            write_reg(addr, data, 4'hf, 0);
            check_read(addr_t'(i << ADDR_LSB), 0);
            addr = addr_t'($urandom);
            addr[6:2] = i[4:0];
            check_read(addr, 0);
        end

        // Back-pressure on B and R
        repeat (16)
        begin
            idx = $urandom_range(REG_COUNT - 1, 0);
            data = $urandom;
            write_reg(addr_t'(idx << ADDR_LSB), data, 4'hf, $urandom_range(8, 1));
            check_read(addr_t'(idx << ADDR_LSB), $urandom_range(8, 1));
        end

        // Exported words follow registers 0 to 3
        for (int i = 0; i < 4; i++)
        begin
            data = $urandom;
            write_reg(addr_t'(i << ADDR_LSB), data, 4'hf, 0);
            check_exports();
        end

        repeat (2) @(negedge clk);
        if (got_q.size() != 0)
        begin
            $display("%0d reads were never compared", got_q.size());
            protocol_errors++;
        end
        $display("Reads compared: %0d, mismatches: %0d, protocol errors: %0d",
                 read_count, mismatch_count, protocol_errors);
        if (mismatch_count == 0 && protocol_errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== common/kg_regfile_pkg.sv ====
// Shared definitions for the AXI4-Lite register file
// Bus widths, register count, response code, data types, FSM state enums

package kg_regfile_pkg;

    // ------------------------------------------------------------
    // Bus and register geometry
    // ------------------------------------------------------------

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Byte offset bits inside one 32-bit word
    localparam int ADDR_LSB = 2;

    localparam int REG_COUNT = 32;
    localparam int INDEX_WIDTH = $clog2(REG_COUNT);

    // Only OKAY is ever returned on B and R
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_e;

    // Read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_DATA
    } rd_state_e;

endpackage

// ==== common/regfile_if.sv ====
// Internal register-access interface
// Carries capture strobes, enables, word indices and write payload

`timescale 1ns/1ps

interface regfile_if;
    import kg_regfile_pkg::*;

    // Write side
    logic aw_capture;
    logic ar_capture;
    logic wr_en;
    index_t wr_index;
    data_t wr_data;
    strb_t wr_strb;

    // Read side
    logic rd_en;
    index_t rd_index;

    // Handshake controller drives the one-cycle strobes
    modport ctrl (
        output aw_capture,
        output ar_capture,
        output wr_en,
        output rd_en
    );

    // Address capture turns the strobes into latched word indices
    modport addr (
        input  aw_capture,
        input  ar_capture,
        output wr_index,
        output rd_index
    );

    // Register bank only listens
    modport bank (
        input aw_capture, ar_capture, wr_en, wr_index, wr_data, wr_strb,
        input rd_en, rd_index
    );

endinterface

// ==== filelist.f ====
+incdir+bench
common/kg_regfile_pkg.sv
common/regfile_if.sv
logic/axil_ctrl.sv
logic/addr_capture.sv
reg_bank/reg_bank.sv
logic/kugelblitz_regfile.sv
bench/tb_kugelblitz_regfile.sv

// ==== logic/addr_capture.sv ====
// Write and read address capture
// Latches the word index of AW and AR addresses on their capture strobes

`timescale 1ns/1ps

module addr_capture (
    input  logic clk,
    input  logic rst,

    input  kg_regfile_pkg::addr_t awaddr,
    input  kg_regfile_pkg::addr_t araddr,

    regfile_if.addr bus
);
    import kg_regfile_pkg::*;

    index_t wr_index_q;
    index_t rd_index_q;

    // Bits above the index are dropped, so the map repeats every 128 bytes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_index_q <= '0;
        end
        else if (bus.aw_capture)
        begin
            wr_index_q <= awaddr[ADDR_LSB +: INDEX_WIDTH];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_index_q <= '0;
        end
        else if (bus.ar_capture)
        begin
            rd_index_q <= araddr[ADDR_LSB +: INDEX_WIDTH];
        end
    end

    assign bus.wr_index = wr_index_q;
    assign bus.rd_index = rd_index_q;

endmodule

// ==== logic/axil_ctrl.sv ====
// AXI4-Lite handshake controller
// Write FSM (AW+W together, then B) and read FSM (AR, then R)
// Produces ready/valid outputs plus capture and enable strobes

`timescale 1ns/1ps

module axil_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic awvalid,
    input  logic wvalid,
    input  logic bready,
    input  logic arvalid,
    input  logic rready,

    output logic awready,
    output logic wready,
    output logic bvalid,
    output logic arready,
    output logic rvalid,

    regfile_if.ctrl bus
);
    import kg_regfile_pkg::*;

    wr_state_e wr_state;
    wr_state_e wr_state_next;
    rd_state_e rd_state;
    rd_state_e rd_state_next;

    // ------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------

    always_comb
    begin
        wr_state_next = wr_state;
        case (wr_state)
            WR_IDLE:
            begin
                // Address and data must both be present
                if (awvalid && wvalid)
                begin
                    wr_state_next = WR_ACCEPT;
                end
            end
            WR_ACCEPT:
            begin
                wr_state_next = WR_RESP;
            end
            WR_RESP:
            begin
                if (bready)
                begin
                    wr_state_next = WR_IDLE;
                end
            end
            default:
            begin
                wr_state_next = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_state <= WR_IDLE;
        end
        else
        begin
            wr_state <= wr_state_next;
        end
    end

    assign bus.aw_capture = (wr_state == WR_IDLE) && awvalid && wvalid;
    assign awready = (wr_state == WR_ACCEPT);
    assign wready = (wr_state == WR_ACCEPT);
    // Register update happens on the AW/W handshake edge
    assign bus.wr_en = (wr_state == WR_ACCEPT) && awvalid && wvalid;
    assign bvalid = (wr_state == WR_RESP);

    // ------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------

    always_comb
    begin
        rd_state_next = rd_state;
        case (rd_state)
            RD_IDLE:
            begin
                if (arvalid)
                begin
                    rd_state_next = RD_ACCEPT;
                end
            end
            RD_ACCEPT:
            begin
                rd_state_next = RD_DATA;
            end
            RD_DATA:
            begin
                // No new address is taken while data is pending
                if (rready)
                begin
                    rd_state_next = RD_IDLE;
                end
            end
            default:
            begin
                rd_state_next = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_state <= RD_IDLE;
        end
        else
        begin
            rd_state <= rd_state_next;
        end
    end

    assign bus.ar_capture = (rd_state == RD_IDLE) && arvalid;
    assign arready = (rd_state == RD_ACCEPT);
    assign bus.rd_en = (rd_state == RD_ACCEPT);
    assign rvalid = (rd_state == RD_DATA);

    // ------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Every accept cycle writes, since the master holds AW and W valid until ready
    a_wr_en_in_accept: assert property (@(posedge clk) disable iff (rst)
        bus.wr_en == (wr_state == WR_ACCEPT))
        else $error("wr_en and WR_ACCEPT disagree");

    a_no_ar_during_r: assert property (@(posedge clk) disable iff (rst)
        !(rvalid && arready))
        else $error("arready raised while read data pending");

endmodule

// ==== logic/kugelblitz_regfile.sv ====
// AXI4-Lite slave register file, top level
// Plain AXI4-Lite ports and the four exported register words
// Wires the handshake controller, address capture and register bank

`timescale 1ns/1ps

module kugelblitz_regfile (
    input  logic clk,
    input  logic rst,

    // Write address and data
    input  kg_regfile_pkg::addr_t s_axil_awaddr,
    input  logic s_axil_awvalid,
    output logic s_axil_awready,
    input  kg_regfile_pkg::data_t s_axil_wdata,
    input  kg_regfile_pkg::strb_t s_axil_wstrb,
    input  logic s_axil_wvalid,
    output logic s_axil_wready,

    // Write response
    output logic [1:0] s_axil_bresp,
    output logic s_axil_bvalid,
    input  logic s_axil_bready,

    // Read address and data
    input  kg_regfile_pkg::addr_t s_axil_araddr,
    input  logic s_axil_arvalid,
    output logic s_axil_arready,
    output kg_regfile_pkg::data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic s_axil_rvalid,
    input  logic s_axil_rready,

    // Registers 0 to 3
    output kg_regfile_pkg::data_t kg_address_valid,
    output kg_regfile_pkg::data_t kg_address,
    output kg_regfile_pkg::data_t kg_data_valid,
    output kg_regfile_pkg::data_t kg_data
);
    import kg_regfile_pkg::*;

    data_t export_words [4];

    regfile_if bus ();

    // Write payload goes straight to the bank
    assign bus.wr_data = s_axil_wdata;
    assign bus.wr_strb = s_axil_wstrb;

    axil_ctrl ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (s_axil_awvalid),
        .wvalid  (s_axil_wvalid),
        .bready  (s_axil_bready),
        .arvalid (s_axil_arvalid),
        .rready  (s_axil_rready),
        .awready (s_axil_awready),
        .wready  (s_axil_wready),
        .bvalid  (s_axil_bvalid),
        .arready (s_axil_arready),
        .rvalid  (s_axil_rvalid),
        .bus     (bus.ctrl)
    );

    addr_capture addr_capture_i (
        .clk    (clk),
        .rst    (rst),
        .awaddr (s_axil_awaddr),
        .araddr (s_axil_araddr),
        .bus    (bus.addr)
    );

    reg_bank reg_bank_i (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.bank),
        .rdata        (s_axil_rdata),
        .export_words (export_words)
    );

    // No error responses exist
    assign s_axil_bresp = RESP_OKAY;
    assign s_axil_rresp = RESP_OKAY;

    assign kg_address_valid = export_words[0];
    assign kg_address = export_words[1];
    assign kg_data_valid = export_words[2];
    assign kg_data = export_words[3];

endmodule

// ==== reg_bank/reg_bank.sv ====
// Register bank of 32 words
// Byte-strobed write port, registered read port, export of words 0 to 3

`timescale 1ns/1ps

module reg_bank (
    input  logic clk,
    input  logic rst,

    regfile_if.bank bus,

    output kg_regfile_pkg::data_t rdata,
    output kg_regfile_pkg::data_t export_words [4]
);
    import kg_regfile_pkg::*;

    data_t regs [REG_COUNT];
    data_t rd_word;

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (bus.wr_en)
        begin
            // Only the strobed byte lanes change
            for (int b = 0; b < STRB_WIDTH; b++)
            begin
                if (bus.wr_strb[b])
                begin
                    regs[bus.wr_index][8*b +: 8] <= bus.wr_data[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    assign rd_word = regs[bus.rd_index];

    // Loaded once per read, held until the next one
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rdata <= '0;
        end
        else if (bus.rd_en)
        begin
            rdata <= rd_word;
        end
    end

    // ------------------------------------------------------------
    // Exported words
    // ------------------------------------------------------------

    for (genvar i = 0; i < 4; i++)
    begin : g_export
        assign export_words[i] = regs[i];
    end

    // A write with no lanes set points at a broken master
    a_wr_strb_nonzero: assert property (@(posedge clk) disable iff (rst)
        bus.wr_en |-> bus.wr_strb != '0)
        else $warning("register write with all strobes low");

endmodule
